// ==== build.f ====
src/fp_add_pkg.sv
src/fp_leading_zero_count.sv
src/fp_operand_compare.sv
src/fp_significand_align.sv
src/fp_significand_add.sv
src/fp_normalize.sv
src/fp_adder.sv
tests/fp_adder_tb.sv

// ==== src/fp_add_pkg.sv ====
// ----------------------------
// Single-precision adder package
// Holds the float word layout, the field widths and the special
// constants shared by every pipeline stage of the adder
// ----------------------------

package fp_add_pkg;

    // ----------------------------
    // Field widths
    // ----------------------------

    // Biased exponent and stored fraction of an IEEE binary32 word
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;

    // Fraction with the hidden bit in front
    localparam int SIG_W  = FRAC_W + 1;

    // Alignment field, aligned addend on top and shifted-out bits below
    localparam int EXT_W  = 2 * SIG_W;

    // Enough bits to count up to SIG_W leading zeros
    localparam int LZC_W  = 5;

    // ----------------------------
    // Special values
    // ----------------------------

    localparam logic [EXP_W-1:0] EXP_MAX_NORMAL = 8'd254;
    localparam logic [EXP_W-1:0] EXP_MIN_NORMAL = 8'd1;

    // Quiet NaN returned for every invalid operation
    localparam logic [EXP_W+FRAC_W:0] CANONICAL_NAN = 32'h7fc00000;

    // A float word is read either field by field or as one raw vector
    typedef union packed {
        logic [EXP_W+FRAC_W:0] raw;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exponent;
            logic [FRAC_W-1:0] fraction;
        } fields;
    } fp32_word_t;

endpackage

// ==== src/fp_adder.sv ====
// ----------------------------
// Pipelined single-precision adder
// Four stages, one operand pair per enabled clock, result truncated
// ----------------------------

`timescale 1ns/1ps

module fp_adder
    import fp_add_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       valid_i,
    input  fp32_word_t operand_a_i,
    input  fp32_word_t operand_b_i,
    input  logic       subtract_i,
    output logic       valid_o,
    output fp32_word_t result_o,
    output logic       invalid_o,
    output logic       overflow_o,
    output logic       underflow_o,
    output logic       inexact_o
);

    // Stage 0 outputs
    fp32_word_t        s0_major;
    logic              s0_minor_sign;
    logic              s0_minor_hidden;
    logic [FRAC_W-1:0] s0_minor_frac;
    logic [EXP_W-1:0]  s0_exp_diff;
    logic              s0_invalid;

    // Stage 1 outputs
    fp32_word_t       s1_major;
    logic             s1_minor_sign;
    logic [SIG_W-1:0] s1_minor_aligned;
    logic [SIG_W-1:0] s1_minor_low;
    logic             s1_invalid;

    // Stage 2 outputs
    fp32_word_t       s2_partial;
    logic             s2_hidden;
    logic             s2_carry;
    logic [SIG_W-1:0] s2_minor_low;
    logic             s2_invalid;

    // One bit per stage, so valid lines up with the result
    logic [3:0] valid_q;

    fp_operand_compare u_compare (
        .clk_i          (clk_i),
        .clk_en_i       (clk_en_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .subtract_i     (subtract_i),
        .major_o        (s0_major),
        .minor_sign_o   (s0_minor_sign),
        .minor_hidden_o (s0_minor_hidden),
        .minor_frac_o   (s0_minor_frac),
        .exp_diff_o     (s0_exp_diff),
        .invalid_o      (s0_invalid)
    );

    fp_significand_align u_align (
        .clk_i           (clk_i),
        .clk_en_i        (clk_en_i),
        .major_i         (s0_major),
        .minor_sign_i    (s0_minor_sign),
        .minor_hidden_i  (s0_minor_hidden),
        .minor_frac_i    (s0_minor_frac),
        .exp_diff_i      (s0_exp_diff),
        .invalid_i       (s0_invalid),
        .major_o         (s1_major),
        .minor_sign_o    (s1_minor_sign),
        .minor_aligned_o (s1_minor_aligned),
        .minor_low_o     (s1_minor_low),
        .invalid_o       (s1_invalid)
    );

    fp_significand_add u_add (
        .clk_i           (clk_i),
        .clk_en_i        (clk_en_i),
        .major_i         (s1_major),
        .minor_sign_i    (s1_minor_sign),
        .minor_aligned_i (s1_minor_aligned),
        .minor_low_i     (s1_minor_low),
        .invalid_i       (s1_invalid),
        .partial_o       (s2_partial),
        .hidden_o        (s2_hidden),
        .carry_o         (s2_carry),
        .minor_low_o     (s2_minor_low),
        .invalid_o       (s2_invalid)
    );

    fp_normalize u_normalize (
        .clk_i       (clk_i),
        .clk_en_i    (clk_en_i),
        .partial_i   (s2_partial),
        .hidden_i    (s2_hidden),
        .carry_i     (s2_carry),
        .minor_low_i (s2_minor_low),
        .invalid_i   (s2_invalid),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .inexact_o   (inexact_o)
    );

    // Valid advances with the data and freezes with it during a stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (clk_en_i) begin
            valid_q <= {valid_q[2:0], valid_i};
        end
    end

    assign valid_o = valid_q[3];

endmodule

// ==== src/fp_leading_zero_count.sv ====
// ----------------------------
// Leading-zero counter
// Counts zeros above the first set bit of a significand
// ----------------------------

`timescale 1ns/1ps

module fp_leading_zero_count
    import fp_add_pkg::*;
(
    input  logic [SIG_W-1:0] significand_i,
    output logic [LZC_W-1:0] zeros_o
);

    logic [LZC_W-1:0] count;

    // Scan upwards so the highest set bit has the last word
    always_comb begin
        count = LZC_W'(SIG_W);
        for (int i = 0; i < SIG_W; i++) begin
            if (significand_i[i]) begin
                count = LZC_W'(SIG_W - 1 - i);
            end
        end
    end

    // An all-zero input reports SIG_W
    assign zeros_o = count;

endmodule

// ==== src/fp_normalize.sv ====
// ----------------------------
// Adder stage 3, normalization
// Brings the sum back to a normalized word, raises the flags and
// replaces invalid results with the canonical quiet NaN
// ----------------------------

`timescale 1ns/1ps

module fp_normalize
    import fp_add_pkg::*;
(
    input  logic             clk_i,
    input  logic             clk_en_i,
    input  fp32_word_t       partial_i,
    input  logic             hidden_i,
    input  logic             carry_i,
    input  logic [SIG_W-1:0] minor_low_i,
    input  logic             invalid_i,
    output fp32_word_t       result_o,
    output logic             invalid_o,
    output logic             overflow_o,
    output logic             underflow_o,
    output logic             inexact_o
);

    logic [SIG_W-1:0] sig;
    logic [LZC_W-1:0] lead_zeros;

    // Extra top bit marks an exponent that went below zero
    logic [EXP_W:0]   exp_after_shift;
    logic [EXP_W-1:0] clamp_shift;
    logic [EXT_W-1:0] ext_shifted;

    fp32_word_t norm;
    logic       overflow;
    logic       underflow;
    logic       guard_bit;
    logic       round_bit;
    logic       sticky_bit;

    fp32_word_t result_q;
    logic       invalid_q;

    assign sig = {hidden_i, partial_i.fields.fraction};

    fp_leading_zero_count u_lzc (
        .significand_i (sig),
        .zeros_o       (lead_zeros)
    );

    assign exp_after_shift = {1'b0, partial_i.fields.exponent}
                           - {{(EXP_W + 1 - LZC_W){1'b0}}, lead_zeros};

    // Largest left shift that still stops at the smallest normal exponent
    assign clamp_shift = (partial_i.fields.exponent == '0) ? '0
                       : partial_i.fields.exponent - EXP_MIN_NORMAL;

    // ----------------------------
    // Normalization
    // ----------------------------

    always_comb begin
        norm        = partial_i;
        ext_shifted = {sig, minor_low_i};
        overflow    = 1'b0;
        underflow   = 1'b0;
        // Without a shift the rounding bits come straight from the lost bits
        guard_bit   = minor_low_i[SIG_W-1];
        round_bit   = minor_low_i[SIG_W-2];
        sticky_bit  = |minor_low_i[SIG_W-3:0];
        if (carry_i) begin
            // The carry becomes the new hidden bit, the old LSB drops out
            norm.fields.fraction = sig[SIG_W-1:1];
            guard_bit  = sig[0];
            round_bit  = minor_low_i[SIG_W-1];
            sticky_bit = |minor_low_i[SIG_W-2:0];
            if (partial_i.fields.exponent == EXP_MAX_NORMAL) begin
                overflow = 1'b1;
            end else if (partial_i.fields.exponent == '1) begin
                // Infinity plus infinity of the same sign stays infinity
                norm.fields.fraction = '0;
            end else begin
                norm.fields.exponent = partial_i.fields.exponent + 1'b1;
            end
        end else if (sig == '0) begin
            // Full cancellation gives positive zero
            norm.raw = '0;
        end else if (lead_zeros != '0) begin
            if (exp_after_shift[EXP_W] || (exp_after_shift == '0)) begin
                norm.fields.exponent = EXP_MIN_NORMAL;
                ext_shifted = {sig, minor_low_i} << clamp_shift;
                underflow   = 1'b1;
            end else begin
                norm.fields.exponent = exp_after_shift[EXP_W-1:0];
                ext_shifted = {sig, minor_low_i} << lead_zeros;
            end
            // Low bits move up into the fraction with the shift
            norm.fields.fraction = ext_shifted[EXT_W-2:SIG_W];
            guard_bit  = ext_shifted[SIG_W-1];
            round_bit  = ext_shifted[SIG_W-2];
            sticky_bit = |ext_shifted[SIG_W-3:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            result_q    <= norm;
            invalid_q   <= invalid_i;
            overflow_o  <= overflow;
            underflow_o <= underflow;
            // Truncation, so any nonzero dropped bit means the result is inexact
            inexact_o   <= guard_bit | round_bit | sticky_bit;
        end
    end

    assign invalid_o    = invalid_q;
    assign result_o.raw = invalid_q ? CANONICAL_NAN : result_q.raw;

endmodule

// ==== src/fp_operand_compare.sv ====
// ----------------------------
// Adder stage 0, operand compare
// Flags specials, applies the subtract sign flip, orders the operands
// by magnitude and forms the exponent distance between them
// ----------------------------

`timescale 1ns/1ps

module fp_operand_compare
    import fp_add_pkg::*;
(
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  fp32_word_t        operand_a_i,
    input  fp32_word_t        operand_b_i,
    input  logic              subtract_i,
    output fp32_word_t        major_o,
    output logic              minor_sign_o,
    output logic              minor_hidden_o,
    output logic [FRAC_W-1:0] minor_frac_o,
    output logic [EXP_W-1:0]  exp_diff_o,
    output logic              invalid_o
);

    // Operand B after the subtract sign flip
    fp32_word_t operand_b;

    logic a_is_inf;
    logic b_is_inf;
    logic a_is_nan;
    logic b_is_nan;

    // Subnormals sit at the same scale as exponent 1
    logic [EXP_W-1:0] a_exp_eff;
    logic [EXP_W-1:0] b_exp_eff;

    // One extra bit so the MSB tells which exponent is larger
    logic [EXP_W:0]   exp_delta;
    logic [EXP_W-1:0] exp_delta_abs;

    fp32_word_t major;
    fp32_word_t minor;
    logic       invalid;

    always_comb begin
        operand_b = operand_b_i;
        operand_b.fields.sign = operand_b_i.fields.sign ^ subtract_i;
    end

    // ----------------------------
    // Special operand detection
    // ----------------------------

    // Infinity is the all-ones exponent with a zero fraction, sign ignored
    assign a_is_inf = operand_a_i.raw[EXP_W+FRAC_W-1:0] == {{EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    assign b_is_inf = operand_b_i.raw[EXP_W+FRAC_W-1:0] == {{EXP_W{1'b1}}, {FRAC_W{1'b0}}};

    assign a_is_nan = (operand_a_i.fields.exponent == '1) && (operand_a_i.fields.fraction != '0);
    assign b_is_nan = (operand_b_i.fields.exponent == '1) && (operand_b_i.fields.fraction != '0);

    // Infinities of opposite effective sign cancel to nothing meaningful
    assign invalid = a_is_nan || b_is_nan
                   || (a_is_inf && b_is_inf && (operand_a_i.fields.sign ^ operand_b.fields.sign));

    // ----------------------------
    // Exponent compare and swap
    // ----------------------------

    assign a_exp_eff = (operand_a_i.fields.exponent == '0) ? EXP_MIN_NORMAL
                                                           : operand_a_i.fields.exponent;
    assign b_exp_eff = (operand_b_i.fields.exponent == '0) ? EXP_MIN_NORMAL
                                                           : operand_b_i.fields.exponent;

    assign exp_delta = {1'b0, a_exp_eff} - {1'b0, b_exp_eff};

    // When B is larger the reversed difference cannot wrap
    assign exp_delta_abs = exp_delta[EXP_W] ? (b_exp_eff - a_exp_eff) : exp_delta[EXP_W-1:0];

    always_comb begin
        if (exp_delta[EXP_W]) begin
            major = operand_b;
            minor = operand_a_i;
        end else if ((exp_delta == '0)
                     && (operand_a_i.raw[EXP_W+FRAC_W-1:0] < operand_b.raw[EXP_W+FRAC_W-1:0])) begin
            // Same scale, so exponent and fraction together decide, hidden bit included
            major = operand_b;
            minor = operand_a_i;
        end else begin
            major = operand_a_i;
            minor = operand_b;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            major_o        <= major;
            minor_sign_o   <= minor.fields.sign;
            minor_hidden_o <= minor.fields.exponent != '0;
            minor_frac_o   <= minor.fields.fraction;
            exp_diff_o     <= exp_delta_abs;
            invalid_o      <= invalid;
        end
    end

endmodule

// ==== src/fp_significand_add.sv ====
// ----------------------------
// Adder stage 2, significand add
// Adds the signed significands and keeps the magnitude of the sum
// ----------------------------

`timescale 1ns/1ps

module fp_significand_add
    import fp_add_pkg::*;
(
    input  logic             clk_i,
    input  logic             clk_en_i,
    input  fp32_word_t       major_i,
    input  logic             minor_sign_i,
    input  logic [SIG_W-1:0] minor_aligned_i,
    input  logic [SIG_W-1:0] minor_low_i,
    input  logic             invalid_i,
    output fp32_word_t       partial_o,
    output logic             hidden_o,
    output logic             carry_o,
    output logic [SIG_W-1:0] minor_low_o,
    output logic             invalid_o
);

    logic major_hidden;

    // One extra bit on top for the carry of an effective addition
    logic [SIG_W:0] major_term;
    logic [SIG_W:0] minor_term;
    logic [SIG_W:0] sum;
    logic           negate_sum;

    logic [SIG_W-1:0] sum_mag;
    logic             same_sign;

    assign major_hidden = major_i.fields.exponent != '0;
    assign same_sign    = major_i.fields.sign == minor_sign_i;

    // The major operand is never smaller, so only the sign pattern matters
    always_comb begin
        major_term = {1'b0, major_hidden, major_i.fields.fraction};
        minor_term = {1'b0, minor_aligned_i};
        negate_sum = 1'b0;
        case ({major_i.fields.sign, minor_sign_i})
            2'b01: begin
                minor_term = -{1'b0, minor_aligned_i};
            end
            2'b10: begin
                // Sum comes out negative and is flipped back below
                major_term = -{1'b0, major_hidden, major_i.fields.fraction};
                negate_sum = 1'b1;
            end
            default: begin
                negate_sum = 1'b0;
            end
        endcase
    end

    assign sum     = major_term + minor_term;
    assign sum_mag = negate_sum ? -sum[SIG_W-1:0] : sum[SIG_W-1:0];

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            // Result keeps the sign and exponent of the major operand for now
            partial_o.fields.sign     <= major_i.fields.sign;
            partial_o.fields.exponent <= major_i.fields.exponent;
            partial_o.fields.fraction <= sum_mag[FRAC_W-1:0];
            hidden_o                  <= sum_mag[SIG_W-1];
            carry_o                   <= sum[SIG_W] & same_sign;
            minor_low_o               <= minor_low_i;
            invalid_o                 <= invalid_i;
        end
    end

endmodule

// ==== src/fp_significand_align.sv ====
// ----------------------------
// Adder stage 1, significand align
// Shifts the minor significand down to the scale of the major one
// ----------------------------

`timescale 1ns/1ps

module fp_significand_align
    import fp_add_pkg::*;
(
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  fp32_word_t        major_i,
    input  logic              minor_sign_i,
    input  logic              minor_hidden_i,
    input  logic [FRAC_W-1:0] minor_frac_i,
    input  logic [EXP_W-1:0]  exp_diff_i,
    input  logic              invalid_i,
    output fp32_word_t        major_o,
    output logic              minor_sign_o,
    output logic [SIG_W-1:0]  minor_aligned_o,
    output logic [SIG_W-1:0]  minor_low_o,
    output logic              invalid_o
);

    // Upper half is the addend, lower half keeps the bits that fell off
    logic [EXT_W-1:0] minor_ext;

    // Past the whole field nothing of the minor operand survives
    assign minor_ext = (exp_diff_i >= EXT_W) ? '0
                     : ({minor_hidden_i, minor_frac_i, {SIG_W{1'b0}}} >> exp_diff_i);

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            major_o         <= major_i;
            minor_sign_o    <= minor_sign_i;
            minor_aligned_o <= minor_ext[EXT_W-1:SIG_W];
            minor_low_o     <= minor_ext[SIG_W-1:0];
            invalid_o       <= invalid_i;
        end
    end

endmodule

// ==== tests/fp_adder_tb.sv ====
// ----------------------------
// Testbench for the pipelined single-precision adder
// Drives directed and random operand pairs, predicts each result from
// the IEEE rules and checks outputs, flags and latency with assertions
// ----------------------------

`timescale 1ns/1ps

module fp_adder_tb;

    localparam int          LATENCY    = 4;
    localparam int          WAIT_LIMIT = 60;
    localparam logic [31:0] SEED       = 32'h2b3a;
    localparam logic [31:0] NAN_WORD   = 32'h7fc00000;

    // Which outputs an operation is judged on
    localparam int MODE_EXACT     = 0;
    localparam int MODE_INVALID   = 1;
    localparam int MODE_INEXACT   = 2;
    localparam int MODE_OVERFLOW  = 3;
    localparam int MODE_UNDERFLOW = 4;

    logic        clk_i;
    logic        rst_n_i;
    logic        clk_en_i;
    logic        valid_i;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic        subtract_i;
    logic        valid_o;
    logic [31:0] result_o;
    logic        invalid_o;
    logic        overflow_o;
    logic        underflow_o;
    logic        inexact_o;

    // Expected operations, oldest first
    string       exp_name_q[$];
    int          exp_mode_q[$];
    logic [31:0] exp_result_q[$];
    int          exp_tag_q[$];

    // Operation currently held on the DUT inputs
    string       cur_name;
    int          cur_mode;
    logic [31:0] cur_expect;

    string       chk_name;
    int          chk_mode;
    logic [31:0] chk_expect;
    int          chk_tag;

    int          enabled_edges;
    logic        advanced;
    logic        last_valid;
    logic [31:0] last_result;
    int          issued;
    int          checks;
    int          errors;
    int unsigned seed_init;

    fp_adder u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .valid_i     (valid_i),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .subtract_i  (subtract_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .inexact_o   (inexact_o)
    );

    always #50 clk_i = ~clk_i;

    // ----------------------------
    // Reference arithmetic
    // ----------------------------

    // Value of a normal binary32 word
    function automatic real to_real(input logic [31:0] w);
        real mag;
        int  e;
        e   = w[30:23];
        mag = (1.0 + $itor(w[22:0]) / 8388608.0) * (2.0 ** (e - 127));
        return w[31] ? -mag : mag;
    endfunction

    // Exact value back to binary32, rebiasing the double exponent from 1023 to 127
    function automatic logic [31:0] from_real(input real r);
        logic [63:0] d;
        logic [10:0] e;
        if (r == 0.0) begin
            return 32'h0;
        end
        d = $realtobits(r);
        e = d[62:52] - 11'd896;
        return {d[63], e[7:0], d[51:29]};
    endfunction

    function automatic logic [31:0] exact_sum(input logic [31:0] a, input logic [31:0] b,
                                              input logic sub);
        real rb;
        rb = sub ? -to_real(b) : to_real(b);
        return from_real(to_real(a) + rb);
    endfunction

    // Low nine fraction bits clear, so an alignment of up to 8 plus a carry shift loses nothing
    function automatic logic [31:0] rand_normal(input int exp_val);
        logic [31:0] w;
        w        = $urandom;
        w[30:23] = exp_val[7:0];
        w[8:0]   = '0;
        return w;
    endfunction

    // ----------------------------
    // Checking
    // ----------------------------

    task automatic check_field(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("error %s %s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name, input int mode, input logic [31:0] res,
                                 input int tag);
        // Result leaves on the fourth enabled edge, counting the edge that took it in
        check_field(name, "latency", tag + LATENCY, enabled_edges);
        case (mode)
            MODE_EXACT: begin
                check_field(name, "result", res, result_o);
                check_field(name, "invalid", 0, invalid_o);
                check_field(name, "overflow", 0, overflow_o);
                check_field(name, "underflow", 0, underflow_o);
                check_field(name, "inexact", 0, inexact_o);
            end
            MODE_INVALID: begin
                check_field(name, "result", res, result_o);
                check_field(name, "invalid", 1, invalid_o);
            end
            MODE_INEXACT: begin
                check_field(name, "result", res, result_o);
                check_field(name, "inexact", 1, inexact_o);
            end
            MODE_OVERFLOW:  check_field(name, "overflow", 1, overflow_o);
            default:        check_field(name, "underflow", 1, underflow_o);
        endcase
    endtask

    // Inputs are stable at the rising edge, since they change 1 ns later
    always @(posedge clk_i) begin
        if (rst_n_i && clk_en_i && valid_i) begin
            exp_name_q.push_back(cur_name);
            exp_mode_q.push_back(cur_mode);
            exp_result_q.push_back(cur_expect);
            exp_tag_q.push_back(enabled_edges);
            issued++;
        end
        if (clk_en_i) begin
            enabled_edges = enabled_edges + 1;
        end
        advanced = clk_en_i;
    end

    // Outputs are compared half a period after the edge that updated them
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (!advanced) begin
                check_field("stall_hold", "valid_o", last_valid, valid_o);
                check_field("stall_hold", "result_o", last_result, result_o);
            end else if (valid_o === 1'b1) begin
                if (exp_name_q.size() == 0) begin
                    errors++;
                    $display("valid_o went high with no operation outstanding");
                end else begin
                    chk_name   = exp_name_q.pop_front();
                    chk_mode   = exp_mode_q.pop_front();
                    chk_expect = exp_result_q.pop_front();
                    chk_tag    = exp_tag_q.pop_front();
                    check_outputs(chk_name, chk_mode, chk_expect, chk_tag);
                end
            end
        end
        last_valid  = valid_o;
        last_result = result_o;
    end

    // ----------------------------
    // Stimulus
    // ----------------------------

    task automatic finish_run();
        $display("issued %0d operations, %0d checks, %0d errors, %0d results missing",
                 issued, checks, errors, exp_name_q.size());
        if (errors == 0 && exp_name_q.size() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while %s, the DUT stopped making progress", what);
        finish_run();
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send_op(input string name, input int mode, input logic [31:0] a,
                           input logic [31:0] b, input logic sub, input logic [31:0] res);
        int   waits;
        logic accepted;
        operand_a  = a;
        operand_b  = b;
        subtract_i = sub;
        valid_i    = 1'b1;
        cur_name   = name;
        cur_mode   = mode;
        cur_expect = res;
        waits      = 0;
        accepted   = 1'b0;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = clk_en_i;
            waits++;
            if (!accepted && waits > WAIT_LIMIT) begin
                report_timeout("issuing an operation");
            end
        end
        #1;
        valid_i = 1'b0;
    endtask

    task automatic send_exact(input string name);
        int          ea;
        int          eb;
        int          d;
        logic [31:0] a;
        logic [31:0] b;
        logic        sub;
        ea  = 40 + $urandom % 161;
        d   = $urandom % 9;
        eb  = ($urandom % 2) ? ea + d : ea - d;
        a   = rand_normal(ea);
        b   = rand_normal(eb);
        sub = $urandom % 2;
        send_op(name, MODE_EXACT, a, b, sub, exact_sum(a, b, sub));
    endtask

    // Garbage held with valid_i high must be ignored while the pipe is frozen
    task automatic pause_pipe(input int cycles);
        operand_a = $urandom;
        operand_b = $urandom;
        valid_i   = 1'b1;
        clk_en_i  = 1'b0;
        repeat (cycles) @(posedge clk_i);
        #1;
        clk_en_i = 1'b1;
        valid_i  = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waits;
        waits = 0;
        do begin
            @(posedge clk_i);
            waits++;
            if (waits > WAIT_LIMIT) begin
                report_timeout("waiting for results to drain");
            end
        end while (exp_name_q.size() != 0);
        #1;
    endtask

    initial begin
        logic [22:0] fa;
        logic [22:0] fb;
        logic        s;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        clk_en_i      = 1'b1;
        valid_i       = 1'b0;
        operand_a     = '0;
        operand_b     = '0;
        subtract_i    = 1'b0;
        enabled_edges = 0;
        advanced      = 1'b0;
        issued        = 0;
        checks        = 0;
        errors        = 0;
        seed_init     = $urandom(SEED);

        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        repeat (30) send_exact("exact_add_sub");
        wait_for_drain();

        // Back-to-back stream, the latency check covers every item
        repeat (12) send_exact("throughput");
        wait_for_drain();

        for (int i = 0; i < 12; i++) begin
            if (i == 4) pause_pipe(5);
            if (i == 9) pause_pipe(2);
            send_exact("stall");
        end
        wait_for_drain();

        send_op("invalid_nan_a", MODE_INVALID, 32'h7fc12345, 32'h3f800000, 1'b0, NAN_WORD);
        send_op("invalid_nan_b", MODE_INVALID, 32'h3f800000, 32'hff800001, 1'b1, NAN_WORD);
        send_op("invalid_inf_add", MODE_INVALID, 32'h7f800000, 32'hff800000, 1'b0, NAN_WORD);
        send_op("invalid_inf_sub", MODE_INVALID, 32'h7f800000, 32'h7f800000, 1'b1, NAN_WORD);

        // 1.0 plus 2^-30 truncates back to 1.0
        send_op("inexact", MODE_INEXACT, 32'h3f800000, 32'h30800000, 1'b0, 32'h3f800000);

        for (int i = 0; i < 4; i++) begin
            s  = $urandom % 2;
            fa = $urandom;
            fb = $urandom;
            send_op("overflow", MODE_OVERFLOW, {s, 8'd254, fa}, {s, 8'd254, fb}, 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            s  = $urandom % 2;
            fa = $urandom;
            fb = fa ^ (23'($urandom % 23'h7fffff) + 23'd1);
            send_op("underflow", MODE_UNDERFLOW, {s, 8'd1, fa}, {s, 8'd1, fb}, 1'b1, '0);
        end
        wait_for_drain();

        // Quiet tail catches any result that shows up twice
        repeat (6) @(posedge clk_i);
        finish_run();
    end

endmodule
